//--- list.f
+incdir+src
src/pcie_route_pkg.sv
src/dma_read_tracker.sv
src/ingress_router.sv
src/egress_router.sv
src/pcie_host_router.sv
testbench/tb_pcie_host_router_asserts.sv
testbench/tb_pcie_host_router.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module tb_pcie_host_router -o sim_tb_pcie_host_router &&
./obj_dir/sim_tb_pcie_host_router | grep "All checks passed" ||
{ echo "simulation did not pass"; exit 1; }

//--- src/dma_read_tracker.sv
/*
  Word counter for DMA reads. While enabled it counts egress strobes up
  to the target word count and then raises finish on the next edge.
  Dropping the enable clears both the count and the finish.
*/

`timescale 1ns/100ps
`default_nettype none

module dma_read_tracker (
  input  logic                  clk,
  input  logic                  rst,

  // DMA is the active read target
  input  logic                  i_en,
  // one word moved by the DMA engine
  input  logic                  i_stb,
  input  pcie_route_pkg::word_t i_word_target,

  output logic                  o_fin
);

  import pcie_route_pkg::*;

  word_t count_q;
  word_t count_d;
  logic  fin_q;
  logic  fin_d;
  logic  below_target;

  assign below_target = (count_q < i_word_target);

  always_comb begin
    count_d = count_q;
    fin_d   = fin_q;

    if (i_en) begin
      if (below_target) begin
        // strobes past the target are not counted
        if (i_stb) begin
          count_d = count_q + 1'b1;
        end
      end else begin
        // reached, also covers a zero word count
        fin_d = 1'b1;
      end
    end else begin
      count_d = '0;
      fin_d   = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= '0;
      fin_q   <= 1'b0;
    end else begin
      count_q <= count_d;
      fin_q   <= fin_d;
    end
  end

  // finish holds until the host drops the read
  assign o_fin = fin_q;

endmodule

`default_nettype wire

//--- src/egress_router.sv
/*
  Host egress FIFO steering. The read target gets the free halves of the
  host egress FIFO; its activate, strobe and data go back to the host.
  Picks read finish, with DMA completion counted by dma_read_tracker.
  All paths are combinational except the DMA finish.
*/

`timescale 1ns/100ps
`default_nettype none

module egress_router (
  input  logic                      clk,
  input  logic                      rst,

  input  pcie_route_pkg::xfer_req_t i_req,

  // host side
  input  pcie_route_pkg::egr_sink_t i_host_egr,
  output pcie_route_pkg::egr_ctl_t  o_host_egr,

  // routed sinks to each target
  output pcie_route_pkg::egr_sink_t o_per_egr,
  output pcie_route_pkg::egr_sink_t o_mem_egr,
  output pcie_route_pkg::egr_sink_t o_dma_egr,

  // producers from each target
  input  pcie_route_pkg::egr_ctl_t  i_per_egr,
  input  pcie_route_pkg::egr_ctl_t  i_mem_egr,
  input  pcie_route_pkg::egr_ctl_t  i_dma_egr,

  input  logic                      i_per_egr_fin,
  input  logic                      i_mem_fin,
  input  logic                      i_mem_egr_inactive,

  output logic                      o_mem_read_en,
  output logic                      o_read_fin
);

  import pcie_route_pkg::*;

  route_target_e rd_tgt;
  logic          dma_read_en;
  logic          dma_read_fin;

  assign rd_tgt = target_of(i_req.per_sel, i_req.mem_sel, i_req.dma_sel, i_req.read_flg);

  always_comb begin
    o_per_egr  = '0;
    o_mem_egr  = '0;
    o_dma_egr  = '0;
    o_host_egr = '0;
    o_read_fin = 1'b0;

    case (rd_tgt)
      TGT_PER: begin
        o_per_egr  = i_host_egr;
        o_host_egr = i_per_egr;
        o_read_fin = i_per_egr_fin;
      end
      TGT_MEM: begin
        o_mem_egr  = i_host_egr;
        o_host_egr = i_mem_egr;
        // memory may report done before its egress side has flushed
        o_read_fin = i_mem_fin & i_mem_egr_inactive;
      end
      TGT_DMA: begin
        o_dma_egr  = i_host_egr;
        o_host_egr = i_dma_egr;
        o_read_fin = dma_read_fin;
      end
      default: begin
        o_read_fin = 1'b0;
      end
    endcase
  end

  assign dma_read_en   = (rd_tgt == TGT_DMA);
  assign o_mem_read_en = (rd_tgt == TGT_MEM);

  // word count for a DMA read comes in the address field
  dma_read_tracker dma_read_tracker_i (
    .clk           (clk),
    .rst           (rst),
    .i_en          (dma_read_en),
    .i_stb         (i_dma_egr.stb),
    .i_word_target (i_req.address),
    .o_fin         (dma_read_fin)
  );

endmodule

`default_nettype wire

//--- src/ingress_router.sv
/*
  Host ingress FIFO steering. The write target is decoded from the
  selects and write flag; only that target sees the host FIFO, and only
  its activate and strobe go back to the host. Also picks write finish.
  Purely combinational.
*/

`timescale 1ns/100ps
`default_nettype none

module ingress_router (
  input  pcie_route_pkg::xfer_req_t i_req,

  // host side
  input  pcie_route_pkg::ing_src_t  i_host_ing,
  output pcie_route_pkg::ing_ctl_t  o_host_ing,

  // routed sources to each target
  output pcie_route_pkg::ing_src_t  o_per_ing,
  output pcie_route_pkg::ing_src_t  o_mem_ing,
  output pcie_route_pkg::ing_src_t  o_dma_ing,

  // consumer controls from each target
  input  pcie_route_pkg::ing_ctl_t  i_per_ing,
  input  pcie_route_pkg::ing_ctl_t  i_mem_ing,
  input  pcie_route_pkg::ing_ctl_t  i_dma_ing,

  input  logic                      i_per_ing_fin,
  input  logic                      i_mem_fin,
  input  logic                      i_host_ing_idle,

  output logic                      o_mem_write_en,
  output logic                      o_write_fin
);

  import pcie_route_pkg::*;

  route_target_e wr_tgt;

  assign wr_tgt = target_of(i_req.per_sel, i_req.mem_sel, i_req.dma_sel, i_req.write_flg);

  always_comb begin
    // losing targets see an idle FIFO
    o_per_ing   = '0;
    o_mem_ing   = '0;
    o_dma_ing   = '0;
    o_host_ing  = '0;
    o_write_fin = 1'b0;

    case (wr_tgt)
      TGT_PER: begin
        o_per_ing   = i_host_ing;
        o_host_ing  = i_per_ing;
        o_write_fin = i_per_ing_fin;
      end
      TGT_MEM: begin
        o_mem_ing   = i_host_ing;
        o_host_ing  = i_mem_ing;
        o_write_fin = i_mem_fin;
      end
      TGT_DMA: begin
        o_dma_ing   = i_host_ing;
        o_host_ing  = i_dma_ing;
        // DMA write is done once the host side drains
        o_write_fin = i_host_ing_idle;
      end
      default: begin
        o_write_fin = 1'b0;
      end
    endcase
  end

  assign o_mem_write_en = (wr_tgt == TGT_MEM);

endmodule

`default_nettype wire

//--- src/pcie_host_router.sv
/*
  Top of the PCIe host routing layer. Connects the host ingress and
  egress ping-pong FIFOs to the peripheral, memory and DMA engines,
  picks the transfer finish flags and forms the memory command.
  Engines attach through the routed channel ports.
*/

`include "pcie_route_cfg.svh"

`timescale 1ns/100ps
`default_nettype none

module pcie_host_router (
  input  logic                      clk,
  input  logic                      rst,

  input  pcie_route_pkg::xfer_req_t i_req,

  // host FIFOs
  input  pcie_route_pkg::ing_src_t  i_host_ing,
  output pcie_route_pkg::ing_ctl_t  o_host_ing,
  input  pcie_route_pkg::egr_sink_t i_host_egr,
  output pcie_route_pkg::egr_ctl_t  o_host_egr,

  // peripheral command engine
  output pcie_route_pkg::ing_src_t  o_per_ing,
  input  pcie_route_pkg::ing_ctl_t  i_per_ing,
  output pcie_route_pkg::egr_sink_t o_per_egr,
  input  pcie_route_pkg::egr_ctl_t  i_per_egr,

  // memory controller
  output pcie_route_pkg::ing_src_t  o_mem_ing,
  input  pcie_route_pkg::ing_ctl_t  i_mem_ing,
  output pcie_route_pkg::egr_sink_t o_mem_egr,
  input  pcie_route_pkg::egr_ctl_t  i_mem_egr,

  // DMA engine
  output pcie_route_pkg::ing_src_t  o_dma_ing,
  input  pcie_route_pkg::ing_ctl_t  i_dma_ing,
  output pcie_route_pkg::egr_sink_t o_dma_egr,
  input  pcie_route_pkg::egr_ctl_t  i_dma_egr,

  input  logic                      i_per_ing_fin,
  input  logic                      i_per_egr_fin,
  input  logic                      i_mem_fin,
  input  logic                      i_mem_egr_inactive,
  input  logic                      i_host_ing_idle,

  output logic                      o_write_fin,
  output logic                      o_read_fin,
  output pcie_route_pkg::mem_cmd_t  o_mem_cmd
);

  import pcie_route_pkg::*;

  logic mem_write_en;
  logic mem_read_en;

  ingress_router ingress_router_i (
    .i_req           (i_req),
    .i_host_ing      (i_host_ing),
    .o_host_ing      (o_host_ing),
    .o_per_ing       (o_per_ing),
    .o_mem_ing       (o_mem_ing),
    .o_dma_ing       (o_dma_ing),
    .i_per_ing       (i_per_ing),
    .i_mem_ing       (i_mem_ing),
    .i_dma_ing       (i_dma_ing),
    .i_per_ing_fin   (i_per_ing_fin),
    .i_mem_fin       (i_mem_fin),
    .i_host_ing_idle (i_host_ing_idle),
    .o_mem_write_en  (mem_write_en),
    .o_write_fin     (o_write_fin)
  );

  egress_router egress_router_i (
    .clk                (clk),
    .rst                (rst),
    .i_req              (i_req),
    .i_host_egr         (i_host_egr),
    .o_host_egr         (o_host_egr),
    .o_per_egr          (o_per_egr),
    .o_mem_egr          (o_mem_egr),
    .o_dma_egr          (o_dma_egr),
    .i_per_egr          (i_per_egr),
    .i_mem_egr          (i_mem_egr),
    .i_dma_egr          (i_dma_egr),
    .i_per_egr_fin      (i_per_egr_fin),
    .i_mem_fin          (i_mem_fin),
    .i_mem_egr_inactive (i_mem_egr_inactive),
    .o_mem_read_en      (mem_read_en),
    .o_read_fin         (o_read_fin)
  );

  // host puts the word address in size and the length in address
  assign o_mem_cmd.write_en  = mem_write_en;
  assign o_mem_cmd.read_en   = mem_read_en;
  assign o_mem_cmd.adr       = i_req.size[`MEM_ADR_W-1:0];
  assign o_mem_cmd.data_size = i_req.address;

endmodule

`default_nettype wire

//--- src/pcie_route_cfg.svh
/*
  Width settings for the PCIe host routing layer.
  Included by the package and by any module that slices a field by width.
*/

`ifndef PCIE_ROUTE_CFG_SVH
`define PCIE_ROUTE_CFG_SVH

// host FIFO data word, also the width of the size and address fields
`define PCIE_DATA_W 32

// ping-pong buffer size count
`define PCIE_FIFO_SIZE_W 24

// egress FIFO has two ping-pong halves
`define PCIE_EGR_CH 2

// memory controller takes a word address, not a byte address
`define MEM_ADR_W 28

`endif

//--- src/pcie_route_pkg.sv
/*
  Shared types for the PCIe host routing layer: the route target,
  the ping-pong FIFO channel structs, the host request, the memory
  command and the select priority decode used by both routers.
*/

`include "pcie_route_cfg.svh"

`default_nettype none

package pcie_route_pkg;

  typedef logic [`PCIE_DATA_W-1:0] word_t;

  typedef enum logic [1:0] {
    TGT_NONE = 2'd0,
    TGT_PER  = 2'd1,
    TGT_MEM  = 2'd2,
    TGT_DMA  = 2'd3
  } route_target_e;

  // host request as presented by the PCIe core
  typedef struct packed {
    logic  per_sel;
    logic  mem_sel;
    logic  dma_sel;
    logic  write_flg;
    logic  read_flg;
    word_t size;
    word_t address;
  } xfer_req_t;

  // ingress FIFO, producer side as seen by a consumer
  typedef struct packed {
    logic                         rdy;
    logic [`PCIE_FIFO_SIZE_W-1:0] size;
    word_t                        data;
  } ing_src_t;

  typedef struct packed {
    logic act;
    logic stb;
  } ing_ctl_t;

  // egress FIFO, free halves as seen by a producer
  typedef struct packed {
    logic [`PCIE_EGR_CH-1:0]      rdy;
    logic [`PCIE_FIFO_SIZE_W-1:0] size;
  } egr_sink_t;

  typedef struct packed {
    logic [`PCIE_EGR_CH-1:0] act;
    logic                    stb;
    word_t                   data;
  } egr_ctl_t;

  typedef struct packed {
    logic                  write_en;
    logic                  read_en;
    logic [`MEM_ADR_W-1:0] adr;
    word_t                 data_size;
  } mem_cmd_t;

  // peripheral beats memory, memory beats DMA
  function automatic route_target_e target_of(
    input logic per_sel,
    input logic mem_sel,
    input logic dma_sel,
    input logic dir_flg
  );
    route_target_e tgt;
    tgt = TGT_NONE;
    if (dir_flg) begin
      if (per_sel) begin
        tgt = TGT_PER;
      end else if (mem_sel) begin
        tgt = TGT_MEM;
      end else if (dma_sel) begin
        tgt = TGT_DMA;
      end
    end
    return tgt;
  endfunction

endpackage

`default_nettype wire

//--- testbench/tb_pcie_host_router.sv
/*
  Testbench for the PCIe host routing layer. Applies a table of selects,
  flags and finish inputs with random FIFO values, checks routing, finish
  selection and the memory command, then runs DMA read word counts.
*/

`include "pcie_route_cfg.svh"

`timescale 1ns/100ps
`default_nettype none

module tb_pcie_host_router;

  import pcie_route_pkg::*;

  // sel is {per, mem, dma}
  // fin is {per_ing_fin, per_egr_fin, mem_fin, mem_egr_inactive, host_ing_idle}
  typedef struct packed {
    logic [2:0]    sel;
    logic          wr;
    logic          rd;
    logic [4:0]    fin;
    route_target_e exp_wr;
    route_target_e exp_rd;
    logic          exp_wfin;
    logic          exp_rfin;
  } row_t;

  localparam int NUM_ROWS = 14;
  localparam route_target_e TGT_ORDER [3] = '{TGT_PER, TGT_MEM, TGT_DMA};

  logic      clk;
  logic      rst;
  xfer_req_t req;
  ing_src_t  host_ing_src;
  ing_ctl_t  host_ing_ctl;
  egr_sink_t host_egr_sink;
  egr_ctl_t  host_egr_ctl;
  // index 0 peripheral, 1 memory, 2 DMA
  ing_src_t  tgt_ing_src [3];
  ing_ctl_t  tgt_ing_ctl [3];
  egr_sink_t tgt_egr_sink [3];
  egr_ctl_t  tgt_egr_ctl [3];
  logic      per_ing_fin, per_egr_fin, mem_fin, mem_egr_inactive, host_ing_idle;
  logic      write_fin, read_fin;
  mem_cmd_t  mem_cmd;
  row_t      rows [NUM_ROWS];
  word_t     word_count;

  pcie_host_router dut_i (
    .clk (clk), .rst (rst), .i_req (req),
    .i_host_ing (host_ing_src), .o_host_ing (host_ing_ctl),
    .i_host_egr (host_egr_sink), .o_host_egr (host_egr_ctl),
    .o_per_ing (tgt_ing_src[0]), .i_per_ing (tgt_ing_ctl[0]),
    .o_per_egr (tgt_egr_sink[0]), .i_per_egr (tgt_egr_ctl[0]),
    .o_mem_ing (tgt_ing_src[1]), .i_mem_ing (tgt_ing_ctl[1]),
    .o_mem_egr (tgt_egr_sink[1]), .i_mem_egr (tgt_egr_ctl[1]),
    .o_dma_ing (tgt_ing_src[2]), .i_dma_ing (tgt_ing_ctl[2]),
    .o_dma_egr (tgt_egr_sink[2]), .i_dma_egr (tgt_egr_ctl[2]),
    .i_per_ing_fin (per_ing_fin), .i_per_egr_fin (per_egr_fin),
    .i_mem_fin (mem_fin), .i_mem_egr_inactive (mem_egr_inactive),
    .i_host_ing_idle (host_ing_idle),
    .o_write_fin (write_fin), .o_read_fin (read_fin), .o_mem_cmd (mem_cmd)
  );

  always #50 clk = ~clk;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic src_match(input string what, input ing_src_t got, input ing_src_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic ctl_match(input string what, input ing_ctl_t got, input ing_ctl_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic sink_match(input string what, input egr_sink_t got, input egr_sink_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic producer_match(input string what, input egr_ctl_t got, input egr_ctl_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic mem_cmd_match(input mem_cmd_t got, input mem_cmd_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED at %0t: memory command is %h, expected %h",
                              $time, got, exp));
    end
  endtask

  task automatic bit_match(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic drive_row(input row_t r);
    int t;
    {req.per_sel, req.mem_sel, req.dma_sel} = r.sel;
    req.write_flg = r.wr;
    req.read_flg  = r.rd;
    req.size      = $urandom;
    // huge word count keeps a DMA read from finishing within a row
    req.address   = $urandom | 32'h8000_0000;
    host_ing_src.rdy   = 1'b1;
    host_ing_src.size  = 24'($urandom);
    host_ing_src.data  = $urandom;
    host_egr_sink.rdy  = 2'($urandom) | 2'b01;
    host_egr_sink.size = 24'($urandom);
    {per_ing_fin, per_egr_fin, mem_fin, mem_egr_inactive, host_ing_idle} = r.fin;
    for (t = 0; t < 3; t++) begin
      tgt_ing_ctl[t]      = 2'($urandom);
      tgt_egr_ctl[t].act  = 2'($urandom);
      tgt_egr_ctl[t].stb  = 1'($urandom);
      tgt_egr_ctl[t].data = $urandom;
    end
  endtask

  task automatic verify_row(input row_t r);
    int        t;
    ing_src_t  exp_src;
    egr_sink_t exp_sink;
    ing_ctl_t  exp_ing;
    egr_ctl_t  exp_egr;
    mem_cmd_t  exp_cmd;
    exp_ing = '0;
    exp_egr = '0;
    for (t = 0; t < 3; t++) begin
      exp_src  = '0;
      exp_sink = '0;
      if (r.exp_wr == TGT_ORDER[t]) begin
        exp_src = host_ing_src;
        exp_ing = tgt_ing_ctl[t];
      end
      if (r.exp_rd == TGT_ORDER[t]) begin
        exp_sink = host_egr_sink;
        exp_egr  = tgt_egr_ctl[t];
      end
      src_match($sformatf("ingress source of target %0d", t), tgt_ing_src[t], exp_src);
      sink_match($sformatf("egress sink of target %0d", t), tgt_egr_sink[t], exp_sink);
    end
    ctl_match("host ingress controls", host_ing_ctl, exp_ing);
    producer_match("host egress producer", host_egr_ctl, exp_egr);
    bit_match("write finish", write_fin, r.exp_wfin);
    bit_match("read finish", read_fin, r.exp_rfin);
    // word address sits in the size field, length in the address field
    exp_cmd.write_en  = (r.exp_wr == TGT_MEM);
    exp_cmd.read_en   = (r.exp_rd == TGT_MEM);
    exp_cmd.adr       = req.size[`MEM_ADR_W-1:0];
    exp_cmd.data_size = req.address;
    mem_cmd_match(mem_cmd, exp_cmd);
  endtask

  task automatic wait_read_fin(output int cycles);
    cycles = 0;
    while (read_fin !== 1'b1) begin
      if (cycles >= 16) begin
        stop_on_error("timed out waiting for the DMA read finish");
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic dma_read_run(input word_t n);
    word_t sent;
    int    guard;
    int    cycles;
    sent  = 0;
    guard = 0;
    // one idle cycle so the tracker starts from a cleared count
    @(posedge clk);
    #1;
    req                = '0;
    tgt_egr_ctl[2].stb = 1'b0;
    @(posedge clk);
    #1;
    req.dma_sel  = 1'b1;
    req.read_flg = 1'b1;
    req.address  = n;
    while (sent < n) begin
      if (guard >= 200) begin
        stop_on_error("DMA strobe loop ran too long");
      end
      tgt_egr_ctl[2].stb = 1'($urandom);
      if (tgt_egr_ctl[2].stb) begin
        sent++;
      end
      @(negedge clk);
      bit_match("read finish while strobing", read_fin, 1'b0);
      @(posedge clk);
      #1;
      guard++;
    end
    tgt_egr_ctl[2].stb = 1'b0;
    @(negedge clk);
    wait_read_fin(cycles);
    if (cycles != 1) begin
      stop_on_error($sformatf("FAILED at %0t: DMA read finish after %0d cycles, expected 1",
                              $time, cycles));
    end
    // a one-cycle drop of read must clear the count and the finish
    @(posedge clk);
    #1;
    req.read_flg = 1'b0;
    @(negedge clk);
    bit_match("read finish with read dropped", read_fin, 1'b0);
    @(posedge clk);
    #1;
    req.read_flg = 1'b1;
    @(negedge clk);
    bit_match("read finish after read returns", read_fin, 1'b0);
    @(posedge clk);
    #1;
    req = '0;
  endtask

  initial begin
    int i;
    void'($urandom(32'hc933));
    clk = 1'b0;
    rst = 1'b1;
    req = '0;
    host_ing_src  = '0;
    host_egr_sink = '0;
    for (i = 0; i < 3; i++) begin
      tgt_ing_ctl[i] = '0;
      tgt_egr_ctl[i] = '0;
    end
    {per_ing_fin, per_egr_fin, mem_fin, mem_egr_inactive, host_ing_idle} = '0;

    // sel, wr, rd, fin, write target, read target, write fin, read fin
    rows[0]  = '{3'b100, 1'b1, 1'b0, 5'b11111, TGT_PER, TGT_NONE, 1'b1, 1'b0};
    rows[1]  = '{3'b010, 1'b1, 1'b0, 5'b11111, TGT_MEM, TGT_NONE, 1'b1, 1'b0};
    rows[2]  = '{3'b001, 1'b1, 1'b0, 5'b11110, TGT_DMA, TGT_NONE, 1'b0, 1'b0};
    rows[3]  = '{3'b001, 1'b1, 1'b0, 5'b00001, TGT_DMA, TGT_NONE, 1'b1, 1'b0};
    rows[4]  = '{3'b100, 1'b0, 1'b1, 5'b01000, TGT_NONE, TGT_PER, 1'b0, 1'b1};
    rows[5]  = '{3'b010, 1'b0, 1'b1, 5'b00100, TGT_NONE, TGT_MEM, 1'b0, 1'b0};
    rows[6]  = '{3'b010, 1'b0, 1'b1, 5'b00110, TGT_NONE, TGT_MEM, 1'b0, 1'b1};
    rows[7]  = '{3'b001, 1'b0, 1'b1, 5'b11111, TGT_NONE, TGT_DMA, 1'b0, 1'b0};
    rows[8]  = '{3'b111, 1'b1, 1'b1, 5'b10000, TGT_PER, TGT_PER, 1'b1, 1'b0};
    rows[9]  = '{3'b011, 1'b1, 1'b1, 5'b00110, TGT_MEM, TGT_MEM, 1'b1, 1'b1};
    rows[10] = '{3'b111, 1'b0, 1'b0, 5'b11111, TGT_NONE, TGT_NONE, 1'b0, 1'b0};
    rows[11] = '{3'b000, 1'b1, 1'b1, 5'b11111, TGT_NONE, TGT_NONE, 1'b0, 1'b0};
    rows[12] = '{3'b101, 1'b1, 1'b1, 5'b01001, TGT_PER, TGT_PER, 1'b0, 1'b1};
    rows[13] = '{3'b001, 1'b1, 1'b1, 5'b00001, TGT_DMA, TGT_DMA, 1'b1, 1'b0};

    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    for (i = 0; i < NUM_ROWS; i++) begin
      @(posedge clk);
      #1;
      drive_row(rows[i]);
      @(negedge clk);
      verify_row(rows[i]);
    end

    word_count = 1 + ($urandom % 12);
    dma_read_run(word_count);
    // zero count finishes one cycle after read goes active
    dma_read_run('0);

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/tb_pcie_host_router_asserts.sv
/*
  Protocol checks for the PCIe host routing layer.
  Bound to every pcie_host_router instance.
*/

`timescale 1ns/100ps
`default_nettype none

module tb_pcie_host_router_asserts (
  input logic                      clk,
  input logic                      rst,
  input pcie_route_pkg::xfer_req_t i_req,
  input pcie_route_pkg::ing_ctl_t  o_host_ing,
  input pcie_route_pkg::egr_ctl_t  o_host_egr,
  input pcie_route_pkg::ing_src_t  o_per_ing,
  input pcie_route_pkg::ing_src_t  o_mem_ing,
  input pcie_route_pkg::ing_src_t  o_dma_ing,
  input pcie_route_pkg::egr_sink_t o_per_egr,
  input pcie_route_pkg::egr_sink_t o_mem_egr,
  input pcie_route_pkg::egr_sink_t o_dma_egr,
  input logic                      dma_read_fin
);

  ing_stb_needs_write: assert property (@(posedge clk) disable iff (rst)
    o_host_ing.stb |-> i_req.write_flg)
    else $error("host ingress strobe without a write flag");

  egr_stb_needs_read: assert property (@(posedge clk) disable iff (rst)
    o_host_egr.stb |-> i_req.read_flg)
    else $error("host egress strobe without a read flag");

  // tracker finish clears the cycle after read drops
  dma_fin_needs_read: assert property (@(posedge clk) disable iff (rst)
    !i_req.read_flg |=> !dma_read_fin)
    else $error("DMA finish set while read is inactive");

  one_ing_ready: assert property (@(posedge clk) disable iff (rst)
    $onehot0({o_per_ing.rdy, o_mem_ing.rdy, o_dma_ing.rdy}))
    else $error("more than one target sees ingress ready");

  one_egr_ready: assert property (@(posedge clk) disable iff (rst)
    $onehot0({|o_per_egr.rdy, |o_mem_egr.rdy, |o_dma_egr.rdy}))
    else $error("more than one target sees egress ready");

endmodule

bind pcie_host_router tb_pcie_host_router_asserts asserts_i (
  .clk          (clk),
  .rst          (rst),
  .i_req        (i_req),
  .o_host_ing   (o_host_ing),
  .o_host_egr   (o_host_egr),
  .o_per_ing    (o_per_ing),
  .o_mem_ing    (o_mem_ing),
  .o_dma_ing    (o_dma_ing),
  .o_per_egr    (o_per_egr),
  .o_mem_egr    (o_mem_egr),
  .o_dma_egr    (o_dma_egr),
  .dma_read_fin (egress_router_i.dma_read_fin)
);

`default_nettype wire
